//--- Bender.yml
package:
  name: axi_slv_wr

sources:
  # RTL in compile order
  - src/axi_wr_pkg.sv
  - src/wr_slot_alloc.sv
  - src/wr_slot.sv
  - src/wr_resp_select.sv
  - src/axi_slv_wr.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/axi_slv_wr_assert.sv
      - sim/tb_axi_slv_wr.sv

//--- sim/axi_slv_wr_assert.sv
module axi_slv_wr_assert
    import axi_wr_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input logic                clk,
    input logic                rst_n,
    input logic                wready,
    input logic                bvalid,
    input logic                bready,
    input logic [ID_WIDTH-1:0] bid,
    input resp_e               bresp
);

    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------------------
    // B channel under back-pressure
    // ----------------------------------------------------------------------

    a_b_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp)
    ) else $error("B channel changed while bvalid waited for bready");

    // Outputs quiet while reset is held
    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !bvalid && !wready
    ) else $error("bvalid or wready high during reset");

endmodule

bind axi_slv_wr axi_slv_wr_assert #(
    .ID_WIDTH (ID_WIDTH)
) i_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .wready (wready),
    .bvalid (bvalid),
    .bready (bready),
    .bid    (bid),
    .bresp  (bresp)
);

//--- sim/tb_axi_slv_wr.sv
module tb_axi_slv_wr
    import axi_wr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int OST_DEPTH      = 8;
    localparam int ID_WIDTH       = 4;
    localparam int RESP_DLY_MAX   = 31;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                clk;
    logic                rst_n;
    logic [ID_WIDTH-1:0] awid;
    logic                awvalid;
    logic                awready;
    logic                wlast;
    logic                wvalid;
    logic                wready;
    logic [ID_WIDTH-1:0] bid;
    resp_e               bresp;
    logic                bvalid;
    logic                bready;

    int errors;
    int checks;
    int cycle_cnt;
    int seed;

    // B handshakes in arrival order
    logic [ID_WIDTH-1:0] rsp_id_q[$];
    resp_e               rsp_code_q[$];

    axi_slv_wr #(
        .OST_DEPTH    (OST_DEPTH),
        .ID_WIDTH     (ID_WIDTH),
        .RESP_DLY_MAX (RESP_DLY_MAX)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .awid    (awid),
        .awvalid (awvalid),
        .awready (awready),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Flop outputs read before the edge updates them
    always @(posedge clk) begin
        if (rst_n && bvalid && bready) begin
            rsp_id_q.push_back(bid);
            rsp_code_q.push_back(bresp);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not end within %0d cycles, %0d errors so far",
                 TIMEOUT_CYCLES, errors);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_resp(input string name, input resp_e exp, input resp_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %s, actual %s (%b)", name, exp.name(), act.name(), act);
        end
    endtask

    task automatic check_id(input string name, input logic [ID_WIDTH-1:0] exp,
                            input logic [ID_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // Bus helpers, all start and end on a falling edge
    // ----------------------------------------------------------------------

    function automatic int resp_delay(input int id);
        return RESP_DLY_MAX - 2 * id;
    endfunction

    task automatic send_aw(input logic [ID_WIDTH-1:0] id);
        awid    = id;
        awvalid = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
    endtask

    task automatic send_burst(input int beats);
        wvalid = 1'b1;
        for (int b = 0; b < beats; b++) begin
            wlast = (b == beats - 1);
            while (!wready) @(negedge clk);
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic wait_responses(input int n);
        while (rsp_id_q.size() < n) @(negedge clk);
    endtask

    task automatic clear_responses();
        rsp_id_q.delete();
        rsp_code_q.delete();
    endtask

    task automatic count_responses(input string name, input int n);
        if (rsp_id_q.size() != n) begin
            errors++;
            $display("%s: saw %0d B responses where %0d were due", name, rsp_id_q.size(), n);
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------

    task automatic test_reset();
        check_level("reset awready", 1'b1, awready);
        check_level("reset wready", 1'b0, wready);
        check_level("reset bvalid", 1'b0, bvalid);
    endtask

    task automatic test_single_write();
        clear_responses();
        send_aw(4'd3);
        // One slot now waits for its burst
        check_level("single write wready pending", 1'b1, wready);
        send_burst(3);
        check_level("single write wready idle", 1'b0, wready);
        wait_responses(1);
        // Long enough for any stray second response
        repeat (RESP_DLY_MAX + 8) @(negedge clk);
        count_responses("single write", 1);
        check_id("single write bid", 4'd3, rsp_id_q[0]);
        check_resp("single write bresp", RESP_OKAY, rsp_code_q[0]);
    endtask

    task automatic test_error_id();
        clear_responses();
        send_aw(4'hf);
        send_burst(2);
        wait_responses(1);
        check_id("error id bid", 4'hf, rsp_id_q[0]);
        check_resp("error id bresp", RESP_SLVERR, rsp_code_q[0]);
    endtask

    task automatic test_out_of_order();
        logic [ID_WIDTH-1:0] first;
        logic [ID_WIDTH-1:0] second;
        clear_responses();
        send_aw(4'd1);
        send_aw(4'd9);
        send_burst(2);
        send_burst(2);
        wait_responses(2);
        // Shorter delay answers first
        first  = (resp_delay(9) < resp_delay(1)) ? 4'd9 : 4'd1;
        second = (first == 4'd9) ? 4'd1 : 4'd9;
        check_id("out of order first bid", first, rsp_id_q[0]);
        check_id("out of order second bid", second, rsp_id_q[1]);
    endtask

    task automatic test_fill_backpressure();
        logic [ID_WIDTH-1:0] ids[OST_DEPTH];
        logic [ID_WIDTH-1:0] held_id;
        int                  issued[1 << ID_WIDTH];
        int                  seen[1 << ID_WIDTH];
        clear_responses();
        for (int i = 0; i < OST_DEPTH; i++) begin
            ids[i] = $random(seed);
            issued[ids[i]]++;
            send_aw(ids[i]);
        end
        check_level("fill awready", 1'b0, awready);
        bready = 1'b0;
        for (int i = 0; i < OST_DEPTH; i++) begin
            send_burst(1 + ({$random(seed)} % 4));
        end
        while (!bvalid) @(negedge clk);
        held_id = bid;
        repeat (10) begin
            @(negedge clk);
            check_level("hold bvalid", 1'b1, bvalid);
            check_id("hold bid", held_id, bid);
        end
        bready = 1'b1;
        wait_responses(OST_DEPTH);
        count_responses("fill", OST_DEPTH);
        foreach (rsp_id_q[i]) seen[rsp_id_q[i]]++;
        for (int id = 0; id < (1 << ID_WIDTH); id++) begin
            if (seen[id] != issued[id]) begin
                errors++;
                $display("error fill id %0h count: expected %0d, actual %0d",
                         id, issued[id], seen[id]);
            end
        end
        check_level("drained awready", 1'b1, awready);
    endtask

    task automatic test_same_id_order();
        logic [ID_WIDTH-1:0] exp_order[3];
        clear_responses();
        send_aw(4'd5);
        send_aw(4'd2);
        send_aw(4'd5);
        repeat (3) send_burst(1);
        wait_responses(3);
        // Both ID 5 writes stay in order, ID 2 falls before or after the pair
        if (resp_delay(2) < resp_delay(5)) exp_order = '{4'd2, 4'd5, 4'd5};
        else exp_order = '{4'd5, 4'd5, 4'd2};
        for (int i = 0; i < 3; i++) begin
            check_id($sformatf("same id order %0d", i), exp_order[i], rsp_id_q[i]);
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        seed    = 32'hd3bb;
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        awid    = '0;
        awvalid = 1'b0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_single_write();
        test_error_id();
        test_out_of_order();
        test_fill_backpressure();
        test_same_id_order();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
src/axi_wr_pkg.sv
src/wr_slot_alloc.sv
src/wr_slot.sv
src/wr_resp_select.sv
src/axi_slv_wr.sv
sim/axi_slv_wr_assert.sv
sim/tb_axi_slv_wr.sv

//--- src/axi_slv_wr.sv
module axi_slv_wr
    import axi_wr_pkg::*;
#(
    parameter int OST_DEPTH    = 8,
    parameter int ID_WIDTH     = 4,
    parameter int RESP_DLY_MAX = 31
) (
    input  logic                clk,
    input  logic                rst_n,
    // AW channel
    input  logic [ID_WIDTH-1:0] awid,
    input  logic                awvalid,
    output logic                awready,
    // W channel
    input  logic                wlast,
    input  logic                wvalid,
    output logic                wready,
    // B channel
    output logic [ID_WIDTH-1:0] bid,
    output resp_e               bresp,
    output logic                bvalid,
    input  logic                bready
);

    logic [OST_DEPTH-1:0]            alloc_vec;
    logic [OST_DEPTH-1:0]            data_done_vec;
    logic [OST_DEPTH-1:0]            dep_mask;
    logic [OST_DEPTH-1:0]            busy_vec;
    logic [OST_DEPTH-1:0]            ready_vec;
    logic [OST_DEPTH-1:0]            done_vec;
    logic [OST_DEPTH*ID_WIDTH-1:0]   slot_id_flat;
    logic [OST_DEPTH*RESP_WIDTH-1:0] slot_resp_flat;

    // ----------------------------------------------------------------------
    // Slot grant and W ordering
    // ----------------------------------------------------------------------

    wr_slot_alloc #(
        .OST_DEPTH (OST_DEPTH),
        .ID_WIDTH  (ID_WIDTH)
    ) i_alloc (
        .clk           (clk),
        .rst_n         (rst_n),
        .awid          (awid),
        .awvalid       (awvalid),
        .wvalid        (wvalid),
        .wlast         (wlast),
        .busy_vec      (busy_vec),
        .slot_id_flat  (slot_id_flat),
        .awready       (awready),
        .wready        (wready),
        .alloc_vec     (alloc_vec),
        .data_done_vec (data_done_vec),
        .dep_mask      (dep_mask)
    );

    // ----------------------------------------------------------------------
    // Outstanding slots
    // ----------------------------------------------------------------------

    for (genvar g = 0; g < OST_DEPTH; g++) begin : gen_slot
        wr_slot #(
            .OST_DEPTH    (OST_DEPTH),
            .ID_WIDTH     (ID_WIDTH),
            .RESP_DLY_MAX (RESP_DLY_MAX)
        ) i_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .alloc      (alloc_vec[g]),
            .awid       (awid),
            .dep_mask   (dep_mask),
            .data_done  (data_done_vec[g]),
            .done       (done_vec[g]),
            .done_vec   (done_vec),
            .busy       (busy_vec[g]),
            .id         (slot_id_flat[g*ID_WIDTH +: ID_WIDTH]),
            .resp_ready (ready_vec[g]),
            .resp       (slot_resp_flat[g*RESP_WIDTH +: RESP_WIDTH])
        );
    end

    // ----------------------------------------------------------------------
    // B channel
    // ----------------------------------------------------------------------

    wr_resp_select #(
        .OST_DEPTH (OST_DEPTH),
        .ID_WIDTH  (ID_WIDTH)
    ) i_select (
        .clk            (clk),
        .rst_n          (rst_n),
        .ready_vec      (ready_vec),
        .slot_id_flat   (slot_id_flat),
        .slot_resp_flat (slot_resp_flat),
        .bready         (bready),
        .bvalid         (bvalid),
        .bid            (bid),
        .bresp          (bresp),
        .done_vec       (done_vec)
    );

endmodule

//--- src/axi_wr_pkg.sv
package axi_wr_pkg;

    // ----------------------------------------------------------------------
    // Shared widths
    // ----------------------------------------------------------------------

    // BRESP width on the B channel
    localparam int RESP_WIDTH = 2;

    // Delay counter, holds RESP_DLY_MAX values up to 63
    localparam int DLY_CNT_WIDTH = 6;

    // ----------------------------------------------------------------------
    // Response codes
    // ----------------------------------------------------------------------

    // Only the two codes this target can return
    typedef enum logic [RESP_WIDTH-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // ----------------------------------------------------------------------
    // Outstanding slot states
    // ----------------------------------------------------------------------

    // IDLE      free, may be granted to the next AW
    // WAIT_DATA address accepted, W burst not yet complete
    // WAIT_DELAY last beat seen, response delay running
    // RESP      response available for the B channel
    typedef enum logic [1:0] {
        SLOT_IDLE       = 2'b00,
        SLOT_WAIT_DATA  = 2'b01,
        SLOT_WAIT_DELAY = 2'b10,
        SLOT_RESP       = 2'b11
    } slot_state_e;

endpackage

//--- src/wr_resp_select.sv
module wr_resp_select
    import axi_wr_pkg::*;
#(
    parameter int OST_DEPTH = 8,
    parameter int ID_WIDTH  = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [OST_DEPTH-1:0]            ready_vec,
    input  logic [OST_DEPTH*ID_WIDTH-1:0]   slot_id_flat,
    input  logic [OST_DEPTH*RESP_WIDTH-1:0] slot_resp_flat,
    input  logic                            bready,
    output logic                            bvalid,
    output logic [ID_WIDTH-1:0]             bid,
    output resp_e                           bresp,
    output logic [OST_DEPTH-1:0]            done_vec
);

    localparam int IDX_W = $clog2(OST_DEPTH);

    logic                 b_hs;
    logic                 load;
    logic [OST_DEPTH-1:0] cand;
    logic                 found;
    logic [IDX_W-1:0]     pick;
    // Slot on the B channel, also the round-robin pointer
    logic [IDX_W-1:0]     sel_idx;

    assign b_hs     = bvalid & bready;
    assign done_vec = b_hs ? (OST_DEPTH'(1) << sel_idx) : '0;
    assign load     = ~bvalid | b_hs;
    assign cand     = ready_vec & ~done_vec;

    // Search starts one past the last grant
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = '0;
        for (int k = 1; k <= OST_DEPTH; k++) begin
            idx = int'(sel_idx) + k;
            if (idx >= OST_DEPTH) idx = idx - OST_DEPTH;
            if (!found && cand[idx]) begin
                found = 1'b1;
                pick  = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid  <= 1'b0;
            sel_idx <= IDX_W'(OST_DEPTH - 1);
        end else if (load) begin
            bvalid <= found;
            if (found) sel_idx <= pick;
        end
    end

    // Held under back-pressure since load stays low
    always_ff @(posedge clk) begin
        if (load && found) begin
            bid   <= slot_id_flat[pick*ID_WIDTH +: ID_WIDTH];
            bresp <= resp_e'(slot_resp_flat[pick*RESP_WIDTH +: RESP_WIDTH]);
        end
    end

endmodule

//--- src/wr_slot.sv
module wr_slot
    import axi_wr_pkg::*;
#(
    parameter int OST_DEPTH    = 8,
    parameter int ID_WIDTH     = 4,
    parameter int RESP_DLY_MAX = 31
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  logic [ID_WIDTH-1:0]  awid,
    input  logic [OST_DEPTH-1:0] dep_mask,
    input  logic                 data_done,
    input  logic                 done,
    input  logic [OST_DEPTH-1:0] done_vec,
    output logic                 busy,
    output logic [ID_WIDTH-1:0]  id,
    output logic                 resp_ready,
    output resp_e                resp
);

    localparam logic [DLY_CNT_WIDTH-1:0] DLY_MAX = DLY_CNT_WIDTH'(RESP_DLY_MAX);

    slot_state_e              state;
    logic [OST_DEPTH-1:0]     dep_q;
    logic [DLY_CNT_WIDTH-1:0] dly_cnt;
    logic [DLY_CNT_WIDTH-1:0] dly_load;

    // Higher IDs answer sooner, two cycles per ID step
    assign dly_load = DLY_MAX - DLY_CNT_WIDTH'({id, 1'b0});

    // ----------------------------------------------------------------------
    // Slot FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SLOT_IDLE;
        end else begin
            case (state)
                SLOT_IDLE: begin
                    if (alloc) state <= SLOT_WAIT_DATA;
                end
                SLOT_WAIT_DATA: begin
                    if (data_done) state <= SLOT_WAIT_DELAY;
                end
                SLOT_WAIT_DELAY: begin
                    if (dly_cnt == DLY_CNT_WIDTH'(1)) state <= SLOT_RESP;
                end
                SLOT_RESP: begin
                    if (done) state <= SLOT_IDLE;
                end
                default: state <= SLOT_IDLE;
            endcase
        end
    end

    // Counts down from the load value, one cycle per step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dly_cnt <= '0;
        end else if (data_done) begin
            dly_cnt <= dly_load;
        end else if (state == SLOT_WAIT_DELAY) begin
            dly_cnt <= dly_cnt - 1'b1;
        end
    end

    // A slot completing in the grant cycle must not be recorded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dep_q <= '0;
        end else if (alloc) begin
            dep_q <= dep_mask & ~done_vec;
        end else begin
            dep_q <= dep_q & ~done_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            id <= awid;
        end
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------

    assign busy       = (state != SLOT_IDLE);
    assign resp_ready = (state == SLOT_RESP) && (dep_q == '0);

    // All-ones ID models a failing target
    assign resp = (id == {ID_WIDTH{1'b1}}) ? RESP_SLVERR : RESP_OKAY;

endmodule

//--- src/wr_slot_alloc.sv
module wr_slot_alloc #(
    parameter int OST_DEPTH = 8,
    parameter int ID_WIDTH  = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [ID_WIDTH-1:0]           awid,
    input  logic                          awvalid,
    input  logic                          wvalid,
    input  logic                          wlast,
    input  logic [OST_DEPTH-1:0]          busy_vec,
    input  logic [OST_DEPTH*ID_WIDTH-1:0] slot_id_flat,
    output logic                          awready,
    output logic                          wready,
    output logic [OST_DEPTH-1:0]          alloc_vec,
    output logic [OST_DEPTH-1:0]          data_done_vec,
    output logic [OST_DEPTH-1:0]          dep_mask
);

    localparam int IDX_W = $clog2(OST_DEPTH);
    localparam int CNT_W = $clog2(OST_DEPTH + 1);

    logic             aw_hs;
    logic             w_last_hs;
    logic [IDX_W-1:0] free_idx;

    // W order queue, one entry per accepted AW
    logic [IDX_W-1:0] order_q [OST_DEPTH];
    logic [IDX_W-1:0] wr_ptr;
    logic [IDX_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [IDX_W-1:0] ptr_inc(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(OST_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Slot grant
    // ----------------------------------------------------------------------

    assign awready = ~&busy_vec;
    assign aw_hs   = awvalid & awready;

    // Lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int j = OST_DEPTH - 1; j >= 0; j--) begin
            if (!busy_vec[j]) begin
                free_idx = IDX_W'(j);
            end
        end
    end

    assign alloc_vec = aw_hs ? (OST_DEPTH'(1) << free_idx) : '0;

    // Older busy slots with the same ID must answer first
    always_comb begin
        for (int j = 0; j < OST_DEPTH; j++) begin
            dep_mask[j] = busy_vec[j] && (slot_id_flat[j*ID_WIDTH +: ID_WIDTH] == awid);
        end
    end

    // ----------------------------------------------------------------------
    // W order queue
    // ----------------------------------------------------------------------

    assign wready    = (count != '0);
    assign w_last_hs = wvalid & wready & wlast;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            order_q[wr_ptr] <= free_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (aw_hs) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (w_last_hs) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Never overflows, a push needs a free slot
            case ({aw_hs, w_last_hs})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue owns the current burst
    assign data_done_vec = w_last_hs ? (OST_DEPTH'(1) << order_q[rd_ptr]) : '0;

endmodule
